// File: tests/music_vectors.txt
# sounding notes in playing order, one per line
# columns: part digit, note length in ms, tone frequency in Hz
1 18 554
1 30 622
1 18 622
1 18 698
1 6 415
2 18 554
2 30 622
2 18 622
2 18 698
2 6 415
3 6 277
3 6 277
3 12 311
3 6 261
3 30 233
4 3 466
4 3 415
4 9 698
4 18 622
4 3 523
4 6 466
5 6 277
5 6 277
5 12 311
5 6 261
5 30 233
6 3 466
6 3 415
6 9 698
6 18 622
6 3 523
6 6 466
1 18 554

// File: list.f
rtl/player_pkg.sv
rtl/song_pkg.sv
rtl/timer_if.sv
rtl/ms_timer.sv
rtl/note_sequencer.sv
rtl/tone_generator.sv
rtl/part_display.sv
rtl/music_player.sv
tests/music_player_assertions.sv
tests/tb_music_player.sv

// File: Bender.yml
package:
  name: music_player

sources:
  - rtl/player_pkg.sv
  - rtl/song_pkg.sv
  - rtl/timer_if.sv
  - rtl/ms_timer.sv
  - rtl/note_sequencer.sv
  - rtl/tone_generator.sv
  - rtl/part_display.sv
  - rtl/music_player.sv
  - target: test
    files:
      - tests/music_player_assertions.sv
      - tests/tb_music_player.sv

// File: tests/tb_music_player.sv
// ############################################################
// testbench for the tune player: note timing, part digit,
// tone toggles and silence between notes, read from vectors
// ############################################################

`timescale 1ns/1ps

module tb_music_player;
  import player_pkg::*;

  localparam int tpm = 4;  // clock ticks per millisecond
  localparam int rise_limit = 400;  // cycles allowed before a note starts
  localparam int fall_slack = 8;
  localparam string vector_file = "tests/music_vectors.txt";

  // display patterns, bit 0 = top, bit 6 = middle
  localparam logic [6:0] digit_pattern [0:9] = '{
    7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
    7'b1101101, 7'b1111100, 7'b0000111, 7'b1111111, 7'b1100111
  };

  logic             clk;
  logic             rst;
  logic [tpm_w-1:0] ticks_per_milli;
  logic             sound;
  logic [seg_w-1:0] segments;
  logic             dot;

  logic             cur_dot;  // sampled at the falling edge
  logic             prev_dot;
  logic             cur_sound;
  logic             prev_sound;
  logic [seg_w-1:0] cur_segments;

  int vec_part[$];
  int vec_len[$];  // ms
  int vec_freq[$];  // Hz

  music_player #(
    .beat_ms (3)
  ) dut_i (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .sound           (sound),
    .segments        (segments),
    .dot             (dot)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, input int tol);
    int diff;
    diff = int'(actual) - int'(expected);
    if (diff < 0) begin
      diff = -diff;
    end
    if ($isunknown(actual) || (diff > tol)) begin
      $display("[FAIL] time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // one sample per cycle, silence rule checked between two dot-low samples
  task automatic sample_outputs();
    @(negedge clk);
    prev_dot     = cur_dot;
    prev_sound   = cur_sound;
    cur_dot      = dot;
    cur_sound    = sound;
    cur_segments = segments;
    if (!prev_dot && !cur_dot) begin
      check_value("sound", 32'(prev_sound), 32'(cur_sound), 0);
    end
  endtask

  task automatic read_vectors();
    int    fd;
    int    n;
    int    p;
    int    l;
    int    f;
    string line;
    fd = $fopen(vector_file, "r");
    if (fd == 0) begin
      abort_run("could not open the vector file");
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%d %d %d", p, l, f);
      if (n == 3) begin  // comment and blank lines give fewer fields
        vec_part.push_back(p);
        vec_len.push_back(l);
        vec_freq.push_back(f);
      end
    end
    $fclose(fd);
    if (vec_part.size() == 0) begin
      abort_run("the vector file holds no notes");
    end
  endtask

  task automatic check_idle_outputs();
    check_value("dot", 32'd0, 32'(cur_dot), 0);
    check_value("sound", 32'd0, 32'(cur_sound), 0);
    check_value("segments", 32'(digit_pattern[1]), 32'(cur_segments), 0);
  endtask

  // waits for the next dot-high interval and measures it
  task automatic play_note(input int idx);
    int wait_cycles;
    int high_cycles;
    int toggles;
    int exp_cycles;
    int exp_toggles;
    wait_cycles = 0;
    while (!cur_dot) begin
      if (wait_cycles >= rise_limit) begin
        abort_run($sformatf("timeout: note %0d never started", idx));
      end
      sample_outputs();
      wait_cycles++;
    end
    exp_cycles  = vec_len[idx] * tpm;
    exp_toggles = 2 * vec_freq[idx] * vec_len[idx] / 1000;
    high_cycles = 0;
    toggles     = 0;
    while (cur_dot) begin
      high_cycles++;
      check_value("segments", 32'(digit_pattern[vec_part[idx]]), 32'(cur_segments), 0);
      if (high_cycles > exp_cycles + fall_slack) begin
        abort_run($sformatf("timeout: note %0d never ended", idx));
      end
      sample_outputs();
      if (cur_dot && (cur_sound != prev_sound)) begin
        toggles++;
      end
    end
    check_value("dot high cycles", 32'(exp_cycles), 32'(high_cycles), 0);
    check_value("sound toggles", 32'(exp_toggles), 32'(toggles), 1);
  endtask

  initial begin
    rst             = 1'b1;
    ticks_per_milli = tpm_w'(tpm);
    cur_dot         = 1'b0;
    prev_dot        = 1'b0;
    cur_sound       = 1'b0;
    prev_sound      = 1'b0;
    cur_segments    = '0;
    read_vectors();
    sample_outputs();  // inside reset
    check_idle_outputs();
    @(posedge clk);
    #1 rst = 1'b0;
    sample_outputs();  // first cycle out of reset
    check_idle_outputs();
    for (int i = 0; i < vec_part.size(); i++) begin
      play_note(i);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: tests/music_player_assertions.sv
// ############################################################
// concurrent checks on the tune player outputs, bound to top
// ############################################################

`timescale 1ns/1ps

module music_player_assertions (
  input logic                         clk,
  input logic                         rst,
  input logic                         sound,
  input logic [player_pkg::seg_w-1:0] segments,
  input logic                         dot
);

  dot_quiet_in_reset: assert property (@(posedge clk) rst |-> !$rose(dot))
    else $error("dot rose while reset was asserted");

  // tone only changes while a note sounds
  sound_still_without_dot: assert property (
    @(posedge clk) disable iff (rst)
    (!dot && !$past(dot)) |-> $stable(sound)
  ) else $error("sound changed while dot was low");

  segments_lit: assert property (@(posedge clk) disable iff (rst) segments != '0)
    else $error("segments went blank");

endmodule

bind music_player music_player_assertions assertions_i (
  .clk      (clk),
  .rst      (rst),
  .sound    (sound),
  .segments (segments),
  .dot      (dot)
);

// File: rtl/music_player.sv
// #########################################################
// tune player top level
// #########################################################

`timescale 1ns/1ps

module music_player #(
  parameter int beat_ms = 100  // tempo
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [player_pkg::tpm_w-1:0] ticks_per_milli,
  output logic                         sound,
  output logic [player_pkg::seg_w-1:0] segments,
  output logic                         dot
);
  import player_pkg::*;

  logic [freq_w-1:0] tone_freq;
  logic [2:0]        part_num;
  logic              sounding;

  timer_if tmr_bus ();

  ms_timer timer_i (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .tmr             (tmr_bus.timer)
  );

  note_sequencer #(
    .beat_ms (beat_ms)
  ) seq_i (
    .clk       (clk),
    .rst       (rst),
    .tmr       (tmr_bus.seq),
    .tone_freq (tone_freq),
    .part_num  (part_num),
    .sounding  (sounding)
  );

  tone_generator tone_i (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .freq            (tone_freq),
    .sound           (sound)
  );

  part_display display_i (
    .part_num (part_num),
    .sounding (sounding),
    .segments (segments),
    .dot      (dot)
  );

endmodule

// File: rtl/part_display.sv
// #########################################################
// 7-segment part number and tone dot
// #########################################################

`timescale 1ns/1ps

module part_display (
  input  logic [2:0]                   part_num,
  input  logic                         sounding,
  output logic [player_pkg::seg_w-1:0] segments,
  output logic                         dot
);
  import player_pkg::*;

  localparam int num_digits = $size(digit_segments);

  always_comb begin
    segments = '0;  // blank outside 0-9
    if (int'(part_num) < num_digits) begin
      segments = digit_segments[part_num];
    end
  end

  assign dot = sounding;

endmodule

// File: rtl/tone_generator.sv
// #########################################################
// phase accumulator square-wave tone
// #########################################################

`timescale 1ns/1ps

module tone_generator (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [player_pkg::tpm_w-1:0]  ticks_per_milli,
  input  logic [player_pkg::freq_w-1:0] freq,
  output logic                          sound
);
  import player_pkg::*;

  localparam int tps_w = tpm_w + 10;  // room for ticks_per_milli * 1000

  logic [tps_w-1:0] ticks_per_sec;
  logic [tps_w-1:0] half_period;
  logic [tps_w-1:0] acc_q;
  logic [tps_w-1:0] acc_sum;
  logic             sound_q;

  assign ticks_per_sec = tps_w'(ticks_per_milli) * tps_w'(1000);
  assign half_period = ticks_per_sec >> 1;
  assign acc_sum = acc_q + tps_w'(freq);

  always_ff @(posedge clk) begin
    if (rst || (freq == '0)) begin
      acc_q   <= '0;
      sound_q <= 1'b0;
    end else if (acc_sum >= half_period) begin
      acc_q   <= acc_sum - half_period;  // keep the remainder phase
      sound_q <= ~sound_q;
    end else begin
      acc_q <= acc_sum;
    end
  end

  // silent as soon as the note stops
  assign sound = sound_q && (freq != '0);

endmodule

// File: rtl/note_sequencer.sv
// #########################################################
// FSM stepping through song parts and notes
// #########################################################

`timescale 1ns/1ps

module note_sequencer #(
  parameter int beat_ms = 100
) (
  input  logic                          clk,
  input  logic                          rst,
  timer_if.seq                          tmr,
  output logic [player_pkg::freq_w-1:0] tone_freq,
  output logic [2:0]                    part_num,
  output logic                          sounding
);
  import player_pkg::*;
  import song_pkg::*;

  localparam int last_note = $size(intro_notes) - 1;
  localparam int last_part = $size(part_order) - 1;

  seq_state_t      state;
  logic [2:0]      part_idx;  // 0-based position in part_order
  logic [2:0]      note_idx;
  part_kind_t      cur_kind;
  note_t           cur_note;
  logic [ms_w-1:0] note_len;
  logic [ms_w-1:0] gap_len;

  assign cur_kind = part_order[part_idx];

  // all three tables share one length
  always_comb begin
    case (cur_kind)
      INTRO:   cur_note = intro_notes[note_idx];
      VERSE:   cur_note = verse_notes[note_idx];
      default: cur_note = chorus_notes[note_idx];
    endcase
  end

  assign note_len = ms_w'(int'(cur_note.beats) * part_beat_mult(cur_kind) * beat_ms);
  assign gap_len = note_len / 3;  // silence after each tone

  // second load restarts the timer for the gap
  assign tmr.load = (state == LOAD) || ((state == PLAY) && tmr.done);
  assign tmr.length_ms = (state == PLAY) ? gap_len : note_len;

  assign sounding = (state == PLAY) && tmr.busy;
  assign tone_freq = sounding ? cur_note.freq : '0;
  assign part_num = part_idx + 3'd1;  // shown as 1 to 6

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= LOAD;
      part_idx <= '0;
      note_idx <= '0;
    end else begin
      case (state)
        LOAD: begin
          if (cur_note.freq != '0) begin
            state <= PLAY;
          end else begin
            state <= REST;  // rest keeps its full length
          end
        end
        PLAY: begin
          if (tmr.done) begin
            state <= GAP;
          end
        end
        default: begin  // GAP and REST
          if (tmr.done) begin
            state <= LOAD;
            if (note_idx == 3'(last_note)) begin
              note_idx <= '0;
              if (part_idx == 3'(last_part)) begin
                part_idx <= '0;  // back to first intro
              end else begin
                part_idx <= part_idx + 3'd1;
              end
            end else begin
              note_idx <= note_idx + 3'd1;
            end
          end
        end
      endcase
    end
  end

endmodule

// File: rtl/ms_timer.sv
// #########################################################
// millisecond prescaler and duration down-counter
// #########################################################

`timescale 1ns/1ps

module ms_timer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [player_pkg::tpm_w-1:0] ticks_per_milli,
  timer_if.timer                       tmr
);
  import player_pkg::*;

  logic [tpm_w-1:0] pre_cnt;  // cycle within current ms, 1-based
  logic [ms_w-1:0]  ms_left;
  logic             busy_q;
  logic             ms_end;

  assign ms_end = (pre_cnt == ticks_per_milli);

  // length_ms zero is never loaded by the sequencer
  assign tmr.done = busy_q && ms_end && (ms_left == ms_w'(1));
  assign tmr.busy = busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      pre_cnt <= '0;
      ms_left <= '0;
    end else if (tmr.load) begin  // restart, even when busy
      busy_q  <= 1'b1;
      pre_cnt <= tpm_w'(1);
      ms_left <= tmr.length_ms;
    end else if (busy_q) begin
      if (ms_end) begin
        pre_cnt <= tpm_w'(1);
        ms_left <= ms_left - ms_w'(1);
        if (ms_left == ms_w'(1)) begin
          busy_q <= 1'b0;  // done cycle was the last one
        end
      end else begin
        pre_cnt <= pre_cnt + tpm_w'(1);
      end
    end
  end

endmodule

// File: rtl/timer_if.sv
// #########################################################
// sequencer to millisecond timer connection
// #########################################################

`timescale 1ns/1ps

interface timer_if;
  import player_pkg::*;

  logic            load;  // one-cycle start pulse
  logic [ms_w-1:0] length_ms;  // valid with load
  logic            done;  // last millisecond ends
  logic            busy;  // counting

  modport seq (
    output load,
    output length_ms,
    input  done,
    input  busy
  );

  modport timer (
    input  load,
    input  length_ms,
    output done,
    output busy
  );

endinterface

// File: rtl/song_pkg.sv
// #########################################################
// note record, part kinds, melody tables and part order
// #########################################################

package song_pkg;

  // freq 0 marks a rest
  typedef struct packed {
    logic [player_pkg::freq_w-1:0] freq;
    logic [3:0]                    beats;
  } note_t;

  typedef enum logic [1:0] {
    INTRO  = 2'd0,
    VERSE  = 2'd1,
    CHORUS = 2'd2
  } part_kind_t;

  localparam note_t intro_notes [0:5] = '{
    '{10'd554, 4'd6},  // c5s
    '{10'd622, 4'd10},  // e5f
    '{10'd622, 4'd6},  // e5f
    '{10'd698, 4'd6},  // f5
    '{10'd0, 4'd4},  // rest
    '{10'd415, 4'd2}  // a4f
  };

  localparam note_t verse_notes [0:5] = '{
    '{10'd0, 4'd2},  // rest
    '{10'd277, 4'd1},  // c4s
    '{10'd277, 4'd1},  // c4s
    '{10'd311, 4'd2},  // e4f
    '{10'd261, 4'd1},  // c4
    '{10'd233, 4'd5}  // b3f
  };

  localparam note_t chorus_notes [0:5] = '{
    '{10'd466, 4'd1},  // b4f
    '{10'd415, 4'd1},  // a4f
    '{10'd698, 4'd3},  // f5
    '{10'd622, 4'd6},  // e5f
    '{10'd523, 4'd1},  // c5
    '{10'd466, 4'd2}  // b4f
  };

  // song layout, parts 1 to 6
  localparam part_kind_t part_order [0:5] = '{
    INTRO, INTRO, VERSE, CHORUS, VERSE, CHORUS
  };

  // verse runs at half tempo
  function automatic int unsigned part_beat_mult(part_kind_t kind);
    return (kind == VERSE) ? 2 : 1;
  endfunction

endpackage

// File: rtl/player_pkg.sv
// #########################################################
// player widths, sequencer states and 7-segment digit table
// #########################################################

package player_pkg;

  localparam int freq_w = 10;  // tone frequency in Hz
  localparam int ms_w = 12;  // durations in milliseconds
  localparam int tpm_w = 16;  // clock ticks per millisecond
  localparam int seg_w = 7;

  // note sequencer FSM
  typedef enum logic [1:0] {
    LOAD = 2'd0,  // fetch note, start timer
    PLAY = 2'd1,  // tone sounding
    GAP  = 2'd2,  // silence after a tone
    REST = 2'd3  // silent note
  } seq_state_t;

  // segment patterns, bit 0 = top, bit 6 = middle
  //      --0--
  //     5     1
  //      --6--
  //     4     2
  //      --3--
  localparam logic [seg_w-1:0] digit_segments [0:9] = '{
    7'b0111111,  // 0
    7'b0000110,  // 1
    7'b1011011,  // 2
    7'b1001111,  // 3
    7'b1100110,  // 4
    7'b1101101,  // 5
    7'b1111100,  // 6
    7'b0000111,  // 7
    7'b1111111,  // 8
    7'b1100111  // 9
  };

endpackage
